// File: design/ddr_params.svh
// Build-time sizes for the DDR lane link
// Included by the link package and by every module that sizes a queue or a lane bus

`ifndef DDR_PARAMS_SVH
`define DDR_PARAMS_SVH

// Data lanes, each carries two bits per clock
`define DDR_LANES 4

// Word width, two beats of 2*DDR_LANES bits
`define DDR_WORD_W 16

// Transmit queue depth, also the sender's starting credit count
`define DDR_TX_DEPTH 4

// Receive buffer depth
`define DDR_RX_DEPTH 8

// Consumer credits loaded at reset
// Must not exceed DDR_RX_DEPTH or the receive buffer can overflow
`define DDR_RX_CREDITS 4

`endif

// File: design/ddr_io_pkg.sv
// Types of the dual-edge input cell
// Imported by the input sampler, the deframer and the top level

`default_nettype none

package ddr_io_pkg;

   //####################################################################
   // Sampling mode of the input cell
   //####################################################################
   typedef enum logic [1:0] {
      MODE_BYPASS    = 2'd0,  // Pin straight through, no fall sample
      MODE_OPPOSITE  = 2'd1,  // Fall sample straight off the negedge
      MODE_SAME      = 2'd2,  // Fall sample moved to the posedge
      MODE_PIPELINED = 2'd3   // Same edge plus one more register
   } ddr_mode_e;

   //####################################################################
   // One lane's pair of samples
   //####################################################################
   typedef struct packed {
      logic rise;  // Posedge sample
      logic fall;  // Negedge sample
   } ddr_sample_t;

endpackage

`default_nettype wire

// File: design/ddr_link_pkg.sv
// Link-level types shared by the transmit path, the receive path and the bench
// Sizes come from the params header

`default_nettype none

`include "ddr_params.svh"

package ddr_link_pkg;

   //####################################################################
   // Payload word
   //####################################################################
   typedef struct packed {
      logic [`DDR_WORD_W-1:0] data;
   } ddr_word_t;

   //####################################################################
   // One clock's worth of lane values
   //####################################################################
   typedef struct packed {
      logic [2*`DDR_LANES-1:0] data;  // Half a word
      logic                    valid; // Beat carries data
      logic                    first; // Low half of a word
   } ddr_beat_t;

   //####################################################################
   // Deframer FSM
   //####################################################################
   typedef enum logic {
      RX_IDLE   = 1'b0,  // Waiting for a first beat
      RX_SECOND = 1'b1   // Low half held, waiting for the high half
   } ddr_rx_state_e;

endpackage

`default_nettype wire

// File: design/ddr_iddr.sv
// Dual-edge input sampler for one lane
// Captures the pin on both clock edges and presents a rise/fall pair whose
// alignment is picked by mode. LATCH_HOLD selects a hold latch for the
// falling capture; leave it at 0 for cycle-based simulation

`default_nettype none

module ddr_iddr
   import ddr_io_pkg::*;
#(
   parameter bit LATCH_HOLD = 1'b0  // 1 = transparent-low latch, 0 = negedge flop
) (
   input  logic        clk,
   input  ddr_mode_e   mode,   // Alignment select
   input  logic        pin,    // Lane input, toggles on both edges
   output ddr_sample_t sample  // Rise and fall samples
);

   logic r_edge_q;   // Posedge capture
   logic f_edge_q;   // Negedge capture
   logic f_align_q;  // Negedge capture retimed to posedge
   logic pipe_r_q;   // Extra stage for pipelined mode
   logic pipe_f_q;

   always_ff @(posedge clk)
      r_edge_q <= pin;

   // Falling capture, latch or flop
   generate
      if (LATCH_HOLD) begin : g_latch
         always_latch begin
            if (!clk)
               f_edge_q <= pin;  // Open while clk low, holds through high phase
         end
      end else begin : g_flop
         always_ff @(negedge clk)
            f_edge_q <= pin;
      end
   endgenerate

   always_ff @(posedge clk) begin
      f_align_q <= f_edge_q;   // Fall data onto the rising edge
      pipe_r_q  <= r_edge_q;
      pipe_f_q  <= f_align_q;
   end

   //####################################################################
   // Output select
   //####################################################################
   always_comb begin
      unique case (mode)
         MODE_BYPASS:    sample = '{rise: pin,      fall: 1'b0};
         MODE_OPPOSITE:  sample = '{rise: r_edge_q, fall: f_edge_q};
         MODE_SAME:      sample = '{rise: r_edge_q, fall: f_align_q};
         MODE_PIPELINED: sample = '{rise: pipe_r_q, fall: pipe_f_q};
         default:        sample = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: design/ddr_tx_serializer.sv
// Transmit side of the lane link
// Queues words from a credit-holding sender and sends each as two beats,
// low half first, over DDR_LANES data lanes plus one framing lane.
// One credit returns per word, in the cycle its second beat leaves

`default_nettype none

`include "ddr_params.svh"

module ddr_tx_serializer
   import ddr_link_pkg::*;
(
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 tx_valid,   // Sender holds a credit
   input  ddr_word_t            tx_word,
   output logic                 tx_credit,  // One pulse per freed entry
   output logic [`DDR_LANES:0]  lanes       // Top lane is framing
);

   localparam int DEPTH = `DDR_TX_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);
   localparam int BW    = 2 * `DDR_LANES;   // Bits per beat

   typedef enum logic {SEQ_LOW, SEQ_HIGH} seq_state_e;

   ddr_word_t           mem [DEPTH];  // Queue storage
   logic [AW-1:0]       wr_ptr;
   logic [AW-1:0]       rd_ptr;
   logic [CW-1:0]       count;
   seq_state_e          state;
   ddr_beat_t           beat;         // This cycle's beat
   logic                pop;
   logic [`DDR_LANES:0] rise_bits;
   logic [`DDR_LANES:0] fall_bits;
   logic [`DDR_LANES:0] rise_q;       // Posedge half of the lane pair
   logic [`DDR_LANES:0] fall_q;       // Negedge half of the lane pair
   logic [`DDR_LANES:0] fall_hold;    // Fall bits parked until negedge

   //####################################################################
   // Word queue
   //####################################################################
   always_ff @(posedge clk)
      if (tx_valid)
         mem[wr_ptr] <= tx_word;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         state     <= SEQ_LOW;
         tx_credit <= 1'b0;
      end else begin
         if (tx_valid)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (tx_valid && !pop)
            count <= count + 1'b1;
         else if (pop && !tx_valid)
            count <= count - 1'b1;
         tx_credit <= pop;                  // Entry freed with the high beat
         if (state == SEQ_HIGH)
            state <= SEQ_LOW;
         else if (count != '0)
            state <= SEQ_HIGH;              // Low beat goes out now
      end
   end

   // Beat sequencer, idle beats stay all zero
   always_comb begin
      beat = '0;
      pop  = 1'b0;
      if (state == SEQ_HIGH) begin
         beat.data  = mem[rd_ptr].data[BW +: BW];
         beat.valid = 1'b1;
         pop        = 1'b1;
      end else if (count != '0) begin
         beat.data  = mem[rd_ptr].data[BW-1:0];
         beat.valid = 1'b1;
         beat.first = 1'b1;
      end
   end

   //####################################################################
   // Dual-edge lane driver
   //####################################################################
   assign rise_bits = {beat.valid, beat.data[`DDR_LANES-1:0]};   // Framing rise = valid
   assign fall_bits = {beat.first, beat.data[BW-1:`DDR_LANES]};  // Framing fall = first

   // XOR pair, lanes show rise bits after posedge and fall bits after negedge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rise_q    <= '0;
         fall_hold <= '0;
      end else begin
         rise_q    <= rise_bits ^ fall_q;
         fall_hold <= fall_bits;
      end
   end

   always_ff @(negedge clk or negedge arst_n) begin
      if (!arst_n)
         fall_q <= '0;
      else
         fall_q <= fall_hold ^ rise_q;
   end

   assign lanes = rise_q ^ fall_q;  // Glitch-free merge of both edges

endmodule

`default_nettype wire

// File: design/ddr_rx_deframer.sv
// Receive front end of the lane link
// One input sampler per lane, framing lane included, then a gearbox that
// rebuilds words from the framing lane. Each half launched by the
// transmitter lands on the opposite receive edge, so tx rise bits arrive
// in the fall samples and tx fall bits in the rise samples

`default_nettype none

`include "ddr_params.svh"

module ddr_rx_deframer
   import ddr_io_pkg::*, ddr_link_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  ddr_mode_e           mode,
   input  logic [`DDR_LANES:0] lanes,
   output logic                word_valid,  // One-cycle pulse per word
   output ddr_word_t           word
);

   localparam int BW = 2 * `DDR_LANES;

   ddr_sample_t [`DDR_LANES:0] samples;
   logic        [`DDR_LANES:0] fall_d;    // Fall samples one cycle late
   logic        [`DDR_LANES:0] fall_sel;  // Fall samples paired with rise
   ddr_beat_t                  beat;
   ddr_rx_state_e              state;
   logic        [BW-1:0]       low_q;     // Held low half

   //####################################################################
   // Lane samplers
   //####################################################################
   for (genvar i = 0; i <= `DDR_LANES; i++) begin : g_lane
      ddr_iddr #(
         .LATCH_HOLD (1'b0)   // Flop capture for cycle simulation
      ) u_iddr (
         .clk    (clk),
         .mode   (mode),
         .pin    (lanes[i]),
         .sample (samples[i])
      );
   end

   // Opposite-edge fall runs half a cycle ahead of its rise partner
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         fall_d <= '0;
      else
         for (int i = 0; i <= `DDR_LANES; i++)
            fall_d[i] <= samples[i].fall;
   end

   // Beat rebuild
   always_comb begin
      for (int i = 0; i <= `DDR_LANES; i++)
         fall_sel[i] = (mode == MODE_OPPOSITE) ? fall_d[i] : samples[i].fall;
      for (int i = 0; i < `DDR_LANES; i++) begin
         beat.data[i]            = fall_sel[i];       // Tx rise half
         beat.data[`DDR_LANES+i] = samples[i].rise;   // Tx fall half
      end
      beat.valid = fall_sel[`DDR_LANES];
      beat.first = samples[`DDR_LANES].rise;
   end

   //####################################################################
   // Gearbox FSM
   //####################################################################
   always_ff @(posedge clk)
      if (beat.valid)
         low_q <= beat.data;   // Only used after a first beat

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= RX_IDLE;
         word_valid <= 1'b0;
      end else begin
         word_valid <= 1'b0;
         if (beat.valid && beat.first)
            state <= RX_SECOND;             // New word, restarts a partial one
         else if (beat.valid && state == RX_SECOND) begin
            state      <= RX_IDLE;
            word_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
      if (beat.valid && !beat.first && state == RX_SECOND)
         word.data <= {beat.data, low_q};   // High half on top

endmodule

`default_nettype wire

// File: design/ddr_rx_credit_fifo.sv
// Receive buffer of the lane link
// Stores rebuilt words and hands one per cycle to the consumer while it
// holds credits. The consumer returns a credit with a one-cycle rx_credit
// pulse; a credit is permission to send, so there is no ready

`default_nettype none

`include "ddr_params.svh"

module ddr_rx_credit_fifo
   import ddr_link_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      in_valid,   // Word from the deframer
   input  ddr_word_t in_word,
   input  logic      rx_credit,  // Consumer returns one credit
   output logic      rx_valid,   // Spends one credit
   output ddr_word_t rx_word
);

   localparam int DEPTH = `DDR_RX_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);
   localparam int KW    = $clog2(`DDR_RX_CREDITS + 1);

   ddr_word_t     mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;     // Words buffered
   logic [KW-1:0] credits;   // Consumer credits on hand
   logic          pop;

   //####################################################################
   // Storage
   //####################################################################
   always_ff @(posedge clk)
      if (in_valid)
         mem[wr_ptr] <= in_word;

   assign pop      = (count != '0) && (credits != '0);
   assign rx_valid = pop;
   assign rx_word  = mem[rd_ptr];   // Head word, meaningful with rx_valid

   //####################################################################
   // Pointers, fill level and credits
   //####################################################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= KW'(`DDR_RX_CREDITS);   // Consumer starts full
      end else begin
         if (in_valid)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (in_valid && !pop)
            count <= count + 1'b1;
         else if (pop && !in_valid)
            count <= count - 1'b1;
         // Spend and return in one cycle cancel
         if (pop && !rx_credit)
            credits <= credits - 1'b1;
         else if (rx_credit && !pop)
            credits <= credits + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: design/ddr_loopback_top.sv
// Loopback top of the DDR lane link
// Transmit lanes feed the receive samplers directly inside one clock domain.
// Supported modes are opposite edge, same edge and pipelined same edge;
// completion is marked only by rx_valid

`default_nettype none

`include "ddr_params.svh"

module ddr_loopback_top
   import ddr_io_pkg::*, ddr_link_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  ddr_mode_e mode,       // Sampling mode, 1 to 3
   input  logic      tx_valid,
   input  ddr_word_t tx_word,
   input  logic      rx_credit,
   output logic      tx_credit,
   output logic      rx_valid,
   output ddr_word_t rx_word
);

   logic [`DDR_LANES:0] lanes;       // Loopback lane bus
   logic                word_valid;
   ddr_word_t           word;

   ddr_tx_serializer u_tx (
      .clk       (clk),
      .arst_n    (arst_n),
      .tx_valid  (tx_valid),
      .tx_word   (tx_word),
      .tx_credit (tx_credit),
      .lanes     (lanes)
   );

   ddr_rx_deframer u_rx (
      .clk        (clk),
      .arst_n     (arst_n),
      .mode       (mode),
      .lanes      (lanes),
      .word_valid (word_valid),
      .word       (word)
   );

   ddr_rx_credit_fifo u_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (word_valid),
      .in_word   (word),
      .rx_credit (rx_credit),
      .rx_valid  (rx_valid),
      .rx_word   (rx_word)
   );

endmodule

`default_nettype wire

// File: bench/ddr_clock_gen.sv
// Bench clock and power-on reset
// 40 ns clock, reset held low for four cycles and released on a falling edge

`default_nettype none

module ddr_clock_gen (
   output logic clk,
   output logic por_n  // Active-low power-on reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 20 ns half period
   end

   initial begin
      por_n <= 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      por_n <= 1'b1;  // Lands after the bench has sampled this edge
   end

endmodule

`default_nettype wire

// File: bench/ddr_loopback_properties.sv
// Concurrent checks on the credit and framing rules of the lane link
// Bound into the loopback top; the failure count is read by the testbench

`default_nettype none

`include "ddr_params.svh"

module ddr_loopback_properties (
   input logic                clk,
   input logic                arst_n,
   input logic [`DDR_LANES:0] lanes,
   input logic                word_valid,
   input logic                tx_credit,
   input logic                rx_valid,
   input logic                rx_credit
);
   timeunit 1ns;
   timeprecision 100ps;

   int   failures = 0;  // Failed assertions so far
   int   credits_q;     // Shadow of the buffer's consumer credits
   logic frame_hi_q;    // High-phase value of the framing lane (beat valid)

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         credits_q <= `DDR_RX_CREDITS;
      else if (rx_valid && !rx_credit)
         credits_q <= credits_q - 1;  // Spent
      else if (rx_credit && !rx_valid)
         credits_q <= credits_q + 1;  // Returned
   end

   always_ff @(negedge clk or negedge arst_n) begin
      if (!arst_n)
         frame_hi_q <= 1'b0;
      else
         frame_hi_q <= lanes[`DDR_LANES];
   end

   //####################################################################
   // Credit rules
   //####################################################################
   a_rx_credit: assert property (@(posedge clk) disable iff (!arst_n)
      rx_valid |-> credits_q != 0)
      else begin
         $error("rx_valid while the consumer credit count is zero");
         failures++;
      end

   a_tx_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      tx_credit |=> !tx_credit)
      else begin
         $error("tx_credit high two cycles in a row");
         failures++;
      end

   //####################################################################
   // Framing rules
   //####################################################################
   // First clocked update after release
   a_no_early_word: assert property (@(posedge clk)
      $rose(arst_n) |=> !word_valid)
      else begin
         $error("word_valid in the first cycle after reset release");
         failures++;
      end

   // Low-phase value is first-beat and needs valid from the high phase
   a_first_has_valid: assert property (@(posedge clk) disable iff (!arst_n)
      lanes[`DDR_LANES] |-> frame_hi_q)
      else begin
         $error("first-beat on the framing lane without beat valid");
         failures++;
      end

endmodule

bind ddr_loopback_top ddr_loopback_properties u_props (
   .clk        (clk),
   .arst_n     (arst_n),
   .lanes      (lanes),
   .word_valid (word_valid),
   .tx_credit  (tx_credit),
   .rx_valid   (rx_valid),
   .rx_credit  (rx_credit)
);

`default_nettype wire

// File: bench/ddr_loopback_tb.sv
// Directed loopback tests of the DDR lane link
// Sends words in every supported mode, checks them against a scoreboard
// queue and keeps both sender and consumer credit counts

`default_nettype none

`include "ddr_params.svh"

module ddr_loopback_tb
   import ddr_io_pkg::*, ddr_link_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int W       = `DDR_WORD_W;
   localparam int TIMEOUT = 200;  // Cycle limit of every wait
   // Outstanding words the two buffers can absorb
   localparam int MAX_OUT = `DDR_TX_DEPTH + `DDR_RX_DEPTH - `DDR_RX_CREDITS;

   logic      clk;
   logic      por_n;
   logic      bench_rst_n;  // Reset between tests
   logic      arst_n;
   ddr_mode_e mode;
   logic      tx_valid;
   ddr_word_t tx_word;
   logic      rx_credit;
   logic      tx_credit;
   logic      rx_valid;
   ddr_word_t rx_word;

   ddr_word_t sb[$];         // Sent, not yet received
   int        tx_credits;    // Sender credit counter
   int        min_credits;   // Lowest sender count seen
   int        rx_owed;       // Consumer credits not yet returned
   bit        hold_credits;  // Consumer withholds returns
   int        tx_pulses;
   int        rx_count;

   assign arst_n = por_n & bench_rst_n;

   ddr_clock_gen u_clk (
      .clk   (clk),
      .por_n (por_n)
   );

   ddr_loopback_top uut (
      .clk       (clk),
      .arst_n    (arst_n),
      .mode      (mode),
      .tx_valid  (tx_valid),
      .tx_word   (tx_word),
      .rx_credit (rx_credit),
      .tx_credit (tx_credit),
      .rx_valid  (rx_valid),
      .rx_word   (rx_word)
   );

   //####################################################################
   // Bench helpers
   //####################################################################
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first error");
   endtask

   // Samples outputs mid-cycle, then sets inputs for the next posedge
   task automatic next_cycle();
      ddr_word_t expected;
      @(negedge clk);
      if (tx_credit) begin
         tx_credits++;
         tx_pulses++;
      end
      if (rx_valid) begin
         assert (sb.size() != 0) else abort_run("rx_valid with no word outstanding");
         expected = sb.pop_front();
         assert (rx_word == expected)
            else abort_run($sformatf("MISMATCH rx_word: got %h expected %h",
                                     rx_word, expected));
         rx_count++;
         rx_owed++;  // Consumer now owes a credit
      end
      assert (uut.u_props.failures == 0) else abort_run("a bound link property failed");
      tx_valid  = 1'b0;
      rx_credit = 1'b0;
      if (!hold_credits && rx_owed > 0) begin
         rx_credit = 1'b1;  // One return per cycle
         rx_owed--;
      end
   endtask

   task automatic send_word(input logic [W-1:0] data);
      int waited = 0;
      while (tx_credits == 0 || sb.size() >= MAX_OUT) begin
         next_cycle();
         waited++;
         assert (waited < TIMEOUT) else abort_run("no sender credit came back in time");
      end
      tx_valid     = 1'b1;
      tx_word.data = data;
      tx_credits--;
      if (tx_credits < min_credits)
         min_credits = tx_credits;
      sb.push_back(tx_word);
      next_cycle();
   endtask

   task automatic wait_drain();
      int waited = 0;
      while (sb.size() != 0 || tx_credits != `DDR_TX_DEPTH || rx_owed != 0) begin
         next_cycle();
         waited++;
         assert (waited < TIMEOUT) else abort_run("words or credits still outstanding");
      end
   endtask

   task automatic apply_reset(input ddr_mode_e m);
      bench_rst_n = 1'b0;
      mode        = m;     // Changed only under reset
      rx_owed     = 0;
      repeat (4) next_cycle();
      bench_rst_n = 1'b1;
      tx_credits  = `DDR_TX_DEPTH;
      min_credits = `DDR_TX_DEPTH;
      sb.delete();
      next_cycle();
   endtask

   function automatic ddr_mode_e supported_mode(input int idx);
      case (idx)
         0:       return MODE_OPPOSITE;
         1:       return MODE_SAME;
         default: return MODE_PIPELINED;
      endcase
   endfunction

   function automatic logic [W-1:0] random_word();
      return W'($urandom);
   endfunction

   //####################################################################
   // Tests
   //####################################################################
   task automatic reset_idle_test();
      for (int i = 0; i < 8; i++) begin
         next_cycle();
         assert (!tx_credit && !rx_valid)
            else abort_run("tx_credit or rx_valid active after reset");
      end
      send_word(random_word());  // Same-edge mode from power-on
      wait_drain();
   endtask

   task automatic mode_sweep();
      for (int m = 0; m < 3; m++) begin
         apply_reset(supported_mode(m));
         for (int n = 0; n < 12; n++)
            send_word(random_word());
         wait_drain();
      end
   endtask

   task automatic tx_credit_return();
      int start;
      start       = tx_pulses;
      min_credits = tx_credits;
      for (int n = 0; n < `DDR_TX_DEPTH; n++)
         send_word(random_word());   // Back to back
      wait_drain();
      assert (tx_pulses - start == `DDR_TX_DEPTH)
         else abort_run($sformatf("MISMATCH tx_credit pulses: got %h expected %h",
                                  tx_pulses - start, `DDR_TX_DEPTH));
      assert (min_credits >= 0) else abort_run("sender credit counter went negative");
   endtask

   task automatic rx_backpressure();
      int start;
      start        = rx_count;
      hold_credits = 1'b1;
      for (int n = 0; n < `DDR_RX_CREDITS + 3; n++)
         send_word(random_word());
      // Window for every word to settle in the receive buffer
      for (int i = 0; i < 60; i++) begin
         next_cycle();
         assert (rx_count - start <= `DDR_RX_CREDITS)
            else abort_run("rx_valid went on without credits");
      end
      assert (rx_count - start == `DDR_RX_CREDITS)
         else abort_run($sformatf("MISMATCH rx_valid count: got %h expected %h",
                                  rx_count - start, `DDR_RX_CREDITS));
      hold_credits = 1'b0;  // Returns release the rest
      wait_drain();
   endtask

   task automatic data_patterns();
      for (int m = 0; m < 3; m++) begin
         apply_reset(supported_mode(m));
         send_word('0);
         send_word('1);
         send_word(16'h5555);
         send_word(16'haaaa);
         for (int i = 0; i < W; i++)
            send_word(W'(1) << i);   // Walking one
         wait_drain();
      end
   endtask

   //####################################################################
   // Run
   //####################################################################
   initial begin
      int          waited;
      int unsigned seed_val;
      mode         = MODE_SAME;
      tx_valid     = 1'b0;
      tx_word      = '0;
      rx_credit    = 1'b0;
      bench_rst_n  = 1'b1;
      hold_credits = 1'b0;
      rx_owed      = 0;
      tx_pulses    = 0;
      rx_count     = 0;
      tx_credits   = `DDR_TX_DEPTH;
      min_credits  = `DDR_TX_DEPTH;
      seed_val     = $urandom(32'he70b_a121);
      waited       = 0;
      while (por_n !== 1'b1) begin   // Still X at time zero
         next_cycle();
         waited++;
         assert (waited < 20) else abort_run("power-on reset was never released");
      end
      reset_idle_test();
      mode_sweep();
      tx_credit_return();
      rx_backpressure();
      data_patterns();
      assert (sb.size() == 0) else abort_run("scoreboard not empty at the end");
      assert (tx_credits == `DDR_TX_DEPTH)
         else abort_run($sformatf("MISMATCH tx_credits: got %h expected %h",
                                  tx_credits, `DDR_TX_DEPTH));
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/ddr_io_pkg.sv
design/ddr_link_pkg.sv
design/ddr_iddr.sv
design/ddr_tx_serializer.sv
design/ddr_rx_deframer.sv
design/ddr_rx_credit_fifo.sv
design/ddr_loopback_top.sv
bench/ddr_clock_gen.sv
bench/ddr_loopback_properties.sv
bench/ddr_loopback_tb.sv

// File: Makefile
# Verilator build and run of the DDR loopback testbench

LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f \
		--top-module ddr_loopback_tb -Mdir obj_dir -o ddr_sim
	./obj_dir/ddr_sim | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
